/* hdl/bp_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sizes shared by the gshare predictor and its outstanding branch queue
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package bp_pkg;

	// global history length, also the width of the hashed table index
	localparam int BH_SIZE = 8;

	// one pattern bit per hashed index
	localparam int PHT_ENTRIES = 2 ** BH_SIZE;

	// low pc bits below this are the byte offset and never enter the hash
	localparam int PC_LSB = 2;

	// outstanding branch queue
	localparam int OBQ_DEPTH = 8;     // entries in flight
	localparam int OBQ_PTR_W = 3;     // head and tail pointer width
	localparam int OBQ_CNT_W = 4;     // occupancy, holds 0 through OBQ_DEPTH

	// pointers wrap by plain overflow, so depth has to match the pointer width
	// and the counter needs one bit more to represent a full queue
	//
	// hash used everywhere
	//   index = history ^ pc[PC_LSB +: BH_SIZE]
	//
	// with BH_SIZE 8 and PC_LSB 2 the pc bits are 9:2

endpackage

/* hdl/gshare.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// gshare direction predictor with global history, one bit pattern table,
// same cycle lookup and rollback on a mispredicted queue head
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module gshare import bp_pkg::*; (
	input  logic               clock,
	input  logic               reset,
	input  logic               enable,            // low while the queue is full
	input  logic               branch_valid,      // fetch presents a branch
	input  logic [31:0]        branch_pc,
	input  logic               obq_pred_valid,    // queue holds at least one entry
	input  logic [BH_SIZE-1:0] obq_gh,            // history the head was predicted under
	input  logic [31:0]        obq_pc,            // pc of the head
	input  logic               clear_en,          // head was mispredicted
	output logic               prediction_valid,
	output logic               prediction_taken,
	output logic [BH_SIZE-1:0] lookup_gh,         // history before the shift
	output logic [BH_SIZE-1:0] ght_out
);

	logic [BH_SIZE-1:0]     ght;          // global history register
	logic [BH_SIZE-1:0]     next_ght;
	logic [PHT_ENTRIES-1:0] pht;          // pattern table, 1 = taken
	logic [PHT_ENTRIES-1:0] next_pht;

	logic [BH_SIZE-1:0]     lookup_idx;
	logic [BH_SIZE-1:0]     repair_idx;
	logic                   lookup_bit;
	logic                   repair_bit;   // what the head was predicted with

	// lookup index, byte offset skipped
	assign lookup_idx = ght ^ branch_pc[PC_LSB +: BH_SIZE];
	assign lookup_bit = pht[lookup_idx];

	// repair index comes from the head's own pc and history
	assign repair_idx = obq_gh ^ obq_pc[PC_LSB +: BH_SIZE];
	assign repair_bit = pht[repair_idx];

	// no prediction while the table and history are being repaired,
	// and none when the queue has no room to record it
	assign prediction_valid = branch_valid & enable & ~clear_en;
	assign prediction_taken = prediction_valid & lookup_bit;

	assign lookup_gh = ght;   // queue stores this with the entry
	assign ght_out   = ght;

	always_comb begin
		next_pht = pht;
		next_ght = ght;

		if (clear_en && obq_pred_valid) begin
			// one bit table, so a wrong guess just flips the entry
			next_pht[repair_idx] = ~repair_bit;
			// the actual outcome is the opposite of what was predicted
			next_ght = {obq_gh[BH_SIZE-2:0], ~repair_bit};
		end else if (prediction_valid) begin
			next_ght = {ght[BH_SIZE-2:0], lookup_bit};   // speculative shift
		end
	end

	// table and history both start at zero, i.e. everything not taken
	always_ff @(posedge clock) begin
		if (reset) begin
			pht <= '0;
			ght <= '0;
		end else begin
			pht <= next_pht;
			ght <= next_ght;
		end
	end

endmodule

/* hdl/branch_queue.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// in order queue of outstanding branch predictions, head compare on
// resolve, pop on a correct outcome and flush on a mispredict
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module branch_queue import bp_pkg::*; (
	input  logic               clock,
	input  logic               reset,
	input  logic               push,              // accepted prediction this cycle
	input  logic [31:0]        push_pc,
	input  logic [BH_SIZE-1:0] push_gh,
	input  logic               push_taken,
	input  logic               resolve_valid,     // oldest branch resolves
	input  logic               resolve_taken,     // its actual direction
	output logic               obq_pred_valid,
	output logic [BH_SIZE-1:0] obq_gh,
	output logic [31:0]        obq_pc,
	output logic               clear_en,
	output logic               full
);

	// pc, history and predicted direction of each entry
	logic [31:0]        entry_pc    [OBQ_DEPTH];
	logic [BH_SIZE-1:0] entry_gh    [OBQ_DEPTH];
	logic               entry_taken [OBQ_DEPTH];

	logic [OBQ_PTR_W-1:0] head;   // oldest entry
	logic [OBQ_PTR_W-1:0] tail;   // next free slot
	logic [OBQ_CNT_W-1:0] count;

	logic head_taken;
	logic pop;

	assign obq_pred_valid = (count != '0);
	assign full           = (count == OBQ_CNT_W'(OBQ_DEPTH));

	// head fields go straight out to the predictor for repair
	assign obq_gh     = entry_gh[head];
	assign obq_pc     = entry_pc[head];
	assign head_taken = entry_taken[head];

	// resolutions come oldest first, so only the head is ever compared
	assign clear_en = resolve_valid & obq_pred_valid & (resolve_taken != head_taken);
	assign pop      = resolve_valid & obq_pred_valid & ~clear_en;

	// write the new entry at the tail
	always_ff @(posedge clock) begin
		if (push) begin
			entry_pc[tail]    <= push_pc;
			entry_gh[tail]    <= push_gh;
			entry_taken[tail] <= push_taken;
		end
	end

	// pointers and occupancy
	always_ff @(posedge clock) begin
		if (reset) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else if (clear_en) begin
			// everything younger than the head is wrong path and is dropped
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			if (push)
				tail <= tail + 1'b1;   // wraps at OBQ_DEPTH
			if (pop)
				head <= head + 1'b1;

			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;   // both or neither leave it alone
			endcase
		end
	end

endmodule

/* hdl/branch_predict_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// branch prediction top, gshare plus its outstanding branch queue
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module branch_predict_top import bp_pkg::*; (
	input  logic               clock,
	input  logic               reset,
	input  logic               branch_valid,      // fetch side
	input  logic [31:0]        branch_pc,
	input  logic               resolve_valid,     // execute side, oldest first
	input  logic               resolve_taken,
	output logic               prediction_valid,
	output logic               prediction_taken,
	output logic               mispredict,
	output logic               queue_full,
	output logic [BH_SIZE-1:0] ght_out
);

	logic               obq_pred_valid;
	logic [BH_SIZE-1:0] obq_gh;
	logic [31:0]        obq_pc;
	logic               clear_en;
	logic [BH_SIZE-1:0] lookup_gh;
	logic               full;

	assign mispredict = clear_en;
	assign queue_full = full;

	// a full queue holds off any new prediction
	gshare u_gshare (
		.clock            (clock),
		.reset            (reset),
		.enable           (~full),
		.branch_valid     (branch_valid),
		.branch_pc        (branch_pc),
		.obq_pred_valid   (obq_pred_valid),
		.obq_gh           (obq_gh),
		.obq_pc           (obq_pc),
		.clear_en         (clear_en),
		.prediction_valid (prediction_valid),
		.prediction_taken (prediction_taken),
		.lookup_gh        (lookup_gh),
		.ght_out          (ght_out)
	);

	// every accepted prediction is recorded with the pre shift history
	branch_queue u_branch_queue (
		.clock          (clock),
		.reset          (reset),
		.push           (prediction_valid),
		.push_pc        (branch_pc),
		.push_gh        (lookup_gh),
		.push_taken     (prediction_taken),
		.resolve_valid  (resolve_valid),
		.resolve_taken  (resolve_taken),
		.obq_pred_valid (obq_pred_valid),
		.obq_gh         (obq_gh),
		.obq_pc         (obq_pc),
		.clear_en       (clear_en),
		.full           (full)
	);

endmodule

/* verification/branch_predict_assert.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// concurrent checks on the outstanding branch queue and its repair strobe,
// bound into every branch_queue instance
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module branch_predict_assert import bp_pkg::*; (
	input logic                 clock,
	input logic                 reset,
	input logic                 push,
	input logic                 resolve_valid,
	input logic                 obq_pred_valid,
	input logic                 clear_en,
	input logic                 full,
	input logic [OBQ_CNT_W-1:0] count
);

	// execute resolves only what the queue holds
	resolve_needs_entry: assert property (
		@(posedge clock) disable iff (reset) resolve_valid |-> obq_pred_valid
	) else $error("resolve_valid arrived while the queue was empty");

	push_needs_room: assert property (
		@(posedge clock) disable iff (reset) push |-> !full
	) else $error("push arrived while the queue was full");

	// a repair always refers to a live head
	clear_needs_head: assert property (
		@(posedge clock) disable iff (reset) clear_en |-> obq_pred_valid
	) else $error("clear_en raised without a valid queue head");

	flush_empties_queue: assert property (
		@(posedge clock) disable iff (reset) clear_en |=> (count == '0)
	) else $error("queue not empty one cycle after a flush");

endmodule

bind branch_queue branch_predict_assert u_branch_predict_assert (
	.clock          (clock),
	.reset          (reset),
	.push           (push),
	.resolve_valid  (resolve_valid),
	.obq_pred_valid (obq_pred_valid),
	.clear_en       (clear_en),
	.full           (full),
	.count          (count)
);

/* verification/branch_predict_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the gshare predictor and branch queue with file driven records,
// a random phase against a behavioral model, value checks and a cycle timeout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module branch_predict_tb import bp_pkg::*; ();

	localparam int REC_WORDS    = 8;      // bv pc rv rt pv pt mp gh
	localparam int MAX_RECORDS  = 128;
	localparam int RANDOM_COUNT = 400;
	localparam int RESET_CYCLES = 8;
	localparam logic [31:0] END_MARK = 32'hffff_ffff;

	logic               clock;
	logic               reset;
	logic               branch_valid;
	logic [31:0]        branch_pc;
	logic               resolve_valid;
	logic               resolve_taken;
	logic               prediction_valid;
	logic               prediction_taken;
	logic               mispredict;
	logic               queue_full;
	logic [BH_SIZE-1:0] ght_out;

	logic [31:0] test_words [0:MAX_RECORDS*REC_WORDS-1];
	int          record_count;
	int          cycle_count = 0;
	int          cycle_limit = 0;   // set once the record count is known
	logic [31:0] rand_state;

	// behavioral model with the queue head at element 0
	logic [PHT_ENTRIES-1:0] model_pht;
	logic [BH_SIZE-1:0]     model_hist;
	logic [31:0]            q_pc   [$];
	logic [BH_SIZE-1:0]     q_hist [$];
	logic                   q_pred [$];

	branch_predict_top u_branch_predict_top (
		.clock            (clock),
		.reset            (reset),
		.branch_valid     (branch_valid),
		.branch_pc        (branch_pc),
		.resolve_valid    (resolve_valid),
		.resolve_taken    (resolve_taken),
		.prediction_valid (prediction_valid),
		.prediction_taken (prediction_taken),
		.mispredict       (mispredict),
		.queue_full       (queue_full),
		.ght_out          (ght_out)
	);

	always #2 clock = ~clock;   // 4 ns period

	// run length guard
	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
			$display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
			end_in_failure();
		end
	end

	task automatic end_in_failure();
		$display("Result: FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("[FAIL] %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
			end_in_failure();
		end
	endtask

	// xorshift32
	function automatic logic [31:0] next_random(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// what the predictor should answer this cycle, from the model state
	task automatic predict_expected(input logic bv, input logic [31:0] pc, input logic rv,
		input logic rt, output logic pv, output logic pt, output logic mp, output logic full);
		logic [BH_SIZE-1:0] idx;
		full = (q_pc.size() == OBQ_DEPTH);
		if (q_pred.size() != 0)
			mp = rv && (rt != q_pred[0]);   // only the oldest is ever resolved
		else
			mp = 1'b0;
		pv  = bv && !full && !mp;
		idx = model_hist ^ pc[PC_LSB +: BH_SIZE];
		pt  = pv && model_pht[idx];
	endtask

	// state change at the clock edge
	task automatic advance_model(input logic [31:0] pc, input logic rv, input logic rt,
		input logic pv, input logic pt, input logic mp);
		logic [BH_SIZE-1:0] idx;
		logic [31:0]        head_pc;
		logic               had_head;
		had_head = (q_pc.size() != 0);
		if (mp) begin
			head_pc = q_pc[0];
			idx = q_hist[0] ^ head_pc[PC_LSB +: BH_SIZE];
			model_pht[idx] = ~model_pht[idx];                    // one bit entry just flips
			model_hist = {q_hist[0][BH_SIZE-2:0], rt};           // rollback plus real outcome
			q_pc.delete();
			q_hist.delete();
			q_pred.delete();
		end else begin
			if (pv) begin
				q_pc.push_back(pc);
				q_hist.push_back(model_hist);   // history before the shift
				q_pred.push_back(pt);
				model_hist = {model_hist[BH_SIZE-2:0], pt};
			end
			if (rv && had_head) begin
				void'(q_pc.pop_front());
				void'(q_hist.pop_front());
				void'(q_pred.pop_front());
			end
		end
	endtask

	// one cycle that starts and ends 1 ns after a rising edge
	task automatic run_cycle(input bit from_file, input logic bv, input logic [31:0] pc,
		input logic rv, input logic rt, input logic exp_pv, input logic exp_pt,
		input logic exp_mp, input logic [BH_SIZE-1:0] exp_gh);
		logic model_pv;
		logic model_pt;
		logic model_mp;
		logic model_full;
		branch_valid  = bv;
		branch_pc     = pc;
		resolve_valid = rv;
		resolve_taken = rt;
		predict_expected(bv, pc, rv, rt, model_pv, model_pt, model_mp, model_full);
		if (!from_file) begin
			exp_pv = model_pv;
			exp_pt = model_pt;
			exp_mp = model_mp;
		end
		#2;   // combinational outputs have settled and the edge is 1 ns away
		check_value("prediction_valid", 32'(prediction_valid), 32'(exp_pv));
		check_value("prediction_taken", 32'(prediction_taken), 32'(exp_pt));
		check_value("mispredict", 32'(mispredict), 32'(exp_mp));
		check_value("queue_full", 32'(queue_full), 32'(model_full));
		advance_model(pc, rv, rt, model_pv, model_pt, model_mp);
		if (!from_file)
			exp_gh = model_hist;
		@(posedge clock);
		#1;
		check_value("ght_out", 32'(ght_out), 32'(exp_gh));
	endtask

	initial begin
		int          base;
		logic [31:0] r;
		logic [31:0] pc;
		logic        bv;
		logic        rv;
		logic        rt;

		clock         = 1'b0;
		reset         = 1'b1;
		branch_valid  = 1'b0;
		branch_pc     = '0;
		resolve_valid = 1'b0;
		resolve_taken = 1'b0;
		model_pht     = '0;
		model_hist    = '0;
		rand_state    = 32'd83;

		$readmemh("verification/branch_predict_tests.txt", test_words);
		record_count = 0;
		while (record_count < MAX_RECORDS &&
			test_words[record_count*REC_WORDS] != END_MARK)
			record_count++;
		if (record_count == 0 || record_count == MAX_RECORDS) begin
			$display("The test file could not be read or has no end marker");
			end_in_failure();
		end
		cycle_limit = 10 * (record_count + RANDOM_COUNT);

		repeat (RESET_CYCLES) @(posedge clock);
		#1;
		reset = 1'b0;

		// directed records
		for (int n = 0; n < record_count; n++) begin
			base = n * REC_WORDS;
			run_cycle(1'b1, test_words[base][0], test_words[base+1], test_words[base+2][0],
				test_words[base+3][0], test_words[base+4][0], test_words[base+5][0],
				test_words[base+6][0], test_words[base+7][BH_SIZE-1:0]);
		end

		// random phase carries on from whatever state the records left
		for (int i = 0; i < RANDOM_COUNT; i++) begin
			rand_state = next_random(rand_state);
			r  = rand_state;
			bv = (r[1:0] != 2'b00);
			pc = 32'h0000_1000 | {24'd0, r[7:2], 2'b00};   // 64 branch sites
			rv = (q_pc.size() != 0) && (r[9:8] != 2'b00);  // never resolve an empty queue
			rt = (r[11:10] == 2'b00) ? r[12] : pc[3];      // mostly a per site pattern
			run_cycle(1'b0, bv, pc, rv, rt, 1'b0, 1'b0, 1'b0, '0);
		end

		$display("Result: PASSED");
		$finish;
	end

endmodule

/* verification/branch_predict_tests.txt */
// columns: branch_valid branch_pc resolve_valid resolve_taken, then expected
// prediction_valid prediction_taken mispredict and ght_out after the edge
// fresh table predicts not taken, history shifts zeros
1 00001000 0 0 1 0 0 00
1 00001004 0 0 1 0 0 00
// head resolves taken, flip and rollback, younger entry dropped
0 00000000 1 1 0 0 1 01
1 00001004 0 0 1 1 0 03
0 00000000 1 1 0 0 0 03
// correct resolutions pop in order
1 00001010 0 0 1 0 0 06
1 00001004 0 0 1 0 0 0c
1 00001030 0 0 1 1 0 19
0 00000000 1 0 0 0 0 19
1 00001000 1 0 1 0 0 32
0 00000000 1 1 0 0 0 32
0 00000000 1 0 0 0 0 32
// mispredict with two younger entries, branch held during repair
1 00001008 0 0 1 0 0 64
1 00001000 0 0 1 0 0 c8
1 0000100c 0 0 1 0 0 90
1 00001000 1 1 0 0 1 65
1 00001154 0 0 1 1 0 cb
0 00000000 1 1 0 0 0 cb
// fill all eight entries
1 00001000 0 0 1 0 0 96
1 00001000 0 0 1 0 0 2c
1 00001000 0 0 1 0 0 58
1 00001000 0 0 1 0 0 b0
1 00001000 0 0 1 0 0 60
1 00001000 0 0 1 0 0 c0
1 00001000 0 0 1 0 0 80
1 00001000 0 0 1 0 0 00
// full, branch held until one correct resolution frees a slot
1 00001000 0 0 0 0 0 00
1 00001000 0 0 0 0 0 00
1 00001000 1 0 0 0 0 00
1 00001000 0 0 1 1 0 01
0 00000000 1 0 0 0 0 01
0 00000000 1 0 0 0 0 01
0 00000000 1 0 0 0 0 01
0 00000000 1 1 0 0 1 61
// learned entry then wrong again, flipped back
1 00001344 0 0 1 1 0 c3
1 00001000 1 0 0 0 1 c2
1 00001344 0 0 1 0 0 84
1 00001000 1 0 1 0 0 08
0 00000000 1 0 0 0 0 08
0 00000000 0 0 0 0 0 08
// taken predictions, second one wrong
1 00001020 0 0 1 1 0 11
1 00001044 0 0 1 1 0 23
1 0000108c 0 0 1 1 0 47
0 00000000 1 1 0 0 0 47
0 00000000 1 0 0 0 1 22
1 00001000 0 0 1 0 0 44
1 00001020 0 0 1 0 0 88
1 00001220 0 0 1 0 0 10
0 00000000 1 0 0 0 0 10
0 00000000 1 0 0 0 0 10
0 00000000 1 1 0 0 1 11
1 00001044 0 0 1 1 0 23
0 00000000 1 1 0 0 0 23
0 00000000 0 0 0 0 0 23
1 0000104c 0 0 1 1 0 47
0 00000000 1 1 0 0 0 47
0 00000000 0 0 0 0 0 47
// end marker
ffffffff 00000000 0 0 0 0 0 00

/* flist.f */
hdl/bp_pkg.sv
hdl/gshare.sv
hdl/branch_queue.sv
hdl/branch_predict_top.sv
verification/branch_predict_assert.sv
verification/branch_predict_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the branch predictor testbench with verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f flist.f --top-module branch_predict_tb \
	-o branch_predict_sim || { echo "verilator build failed"; exit 1; }
./obj_dir/branch_predict_sim > sim.log 2>&1 || echo "simulator exited with an error status"
cat sim.log
grep -qx "Result: PASSED" sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
exit 0
